// File: axi_flash_slave.sv
`timescale 1ns/1ps
`default_nettype none

module axi_flash_slave
    import axi_lite_pkg::*;
#(
    parameter int FLASH_ADDR_BITS = 24
) (
    input  logic                       bus,
    input  logic                       rst,
    input  axi_req_t                   req,
    output axi_rsp_t                   rsp,
    output logic                       start_read,
    output logic [FLASH_ADDR_BITS-1:0] read_addr,
    output logic                       keep_reading,
    input  logic                       byte_valid,
    input  logic [7:0]                 data_byte
);

    localparam int BEAT_BYTES = 8;
    localparam int CNT_BITS   = $clog2(BEAT_BYTES + 1);

    logic                arready_q;
    logic                rvalid_q;
    logic                wr_ack_q;
    logic                bvalid_q;
    logic [CNT_BITS-1:0] byte_cnt;
    logic [63:0]         rdata_q;
    logic                ar_hs;
    logic                r_hs;
    logic                w_hs;

    assign ar_hs = arready_q && req.arvalid;
    assign r_hs  = rvalid_q && req.rready;
    assign w_hs  = wr_ack_q && req.awvalid && req.wvalid;

    // Flash access starts on the AR handshake itself
    assign start_read   = ar_hs;
    assign read_addr    = req.araddr[FLASH_ADDR_BITS-1:0];
    assign keep_reading = |byte_cnt;

    // Bytes still expected from the flash
    always_ff @(posedge bus) begin
        if (rst) begin
            byte_cnt <= '0;
        end else if (ar_hs) begin
            byte_cnt <= CNT_BITS'(BEAT_BYTES);
        end else if (byte_valid) begin
            byte_cnt <= byte_cnt - 1'b1;
        end
    end

    // Lowest address ends up in the low byte after eight shifts
    always_ff @(posedge bus) begin
        if (byte_valid) begin
            rdata_q <= {data_byte, rdata_q[63:8]};
        end
    end

    // One read in flight, arready returns after the R handshake
    always_ff @(posedge bus) begin
        if (rst) begin
            arready_q <= 1'b1;
        end else if (ar_hs) begin
            arready_q <= 1'b0;
        end else if (r_hs) begin
            arready_q <= 1'b1;
        end
    end

    always_ff @(posedge bus) begin
        if (rst) begin
            rvalid_q <= 1'b0;
        end else if (r_hs) begin
            rvalid_q <= 1'b0;
        end else if (byte_valid && byte_cnt == CNT_BITS'(1)) begin
            rvalid_q <= 1'b1;
        end
    end

    // Writes are not supported
    always_ff @(posedge bus) begin
        if (rst) begin
            wr_ack_q <= 1'b0;
            bvalid_q <= 1'b0;
        end else begin
            wr_ack_q <= req.awvalid && req.wvalid && !wr_ack_q && !bvalid_q;
            if (bvalid_q && req.bready) begin
                bvalid_q <= 1'b0;
            end else if (w_hs) begin
                bvalid_q <= 1'b1;
            end
        end
    end

    always_comb begin
        rsp.awready = wr_ack_q;
        rsp.wready  = wr_ack_q;
        rsp.bvalid  = bvalid_q;
        rsp.bresp   = SLVERR;
        rsp.arready = arready_q;
        rsp.rvalid  = rvalid_q;
        rsp.rdata   = rdata_q;
        rsp.rresp   = OKAY;
    end

    // Read data held under back-pressure
    r_hold_a: assert property (@(posedge bus) disable iff (rst)
        rvalid_q && !req.rready |=> rvalid_q && $stable(rdata_q));

    // The flash must not deliver into a beat still waiting for rready
    no_overrun_a: assert property (@(posedge bus) disable iff (rst)
        rvalid_q |-> !byte_valid);

    start_addr_known_a: assert property (@(posedge bus) disable iff (rst)
        start_read |-> !$isunknown(read_addr));

endmodule

`default_nettype wire

// File: axi_lite_pkg.sv
`default_nettype none

package axi_lite_pkg;

    // Response codes, only the two this slave ever returns
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axi_resp_e;

    // Signals driven by the master
    typedef struct packed {
        // Write address channel
        logic        awvalid;
        logic [31:0] awaddr;
        // Write data channel
        logic        wvalid;
        logic [63:0] wdata;
        logic [7:0]  wstrb;
        // Write response channel
        logic        bready;
        // Read address channel
        logic        arvalid;
        logic [31:0] araddr;
        // Read data channel
        logic        rready;
    } axi_req_t;

    // Signals driven by the slave
    typedef struct packed {
        logic        awready;
        logic        wready;
        logic        bvalid;
        axi_resp_e   bresp;
        logic        arready;
        logic        rvalid;
        logic [63:0] rdata;
        axi_resp_e   rresp;
    } axi_rsp_t;

endpackage

`default_nettype wire

// File: flash_xip_top.f
axi_lite_pkg.sv
qspi_pkg.sv
qspi_cycle_counter.sv
qspi_shifter.sv
qspi_sequencer.sv
axi_flash_slave.sv
flash_xip_top.sv
qspi_flash_model.sv
tb_flash_xip.sv

// File: flash_xip_top.sv
`timescale 1ns/1ps
`default_nettype none

module flash_xip_top
    import axi_lite_pkg::*;
    import qspi_pkg::*;
#(
    parameter int FLASH_ADDR_BITS = 24,
    parameter int DUMMY_CYCLES    = 8
) (
    input  logic       bus,
    input  logic       rst,
    input  axi_req_t   req,
    output axi_rsp_t   rsp,
    output qspi_pins_t pins,
    input  logic [3:0] io_in
);

    logic                       start_read;
    logic [FLASH_ADDR_BITS-1:0] read_addr;
    logic                       keep_reading;
    logic                       byte_valid;
    logic [7:0]                 data_byte;
    logic                       cnt_load;
    logic [7:0]                 cnt_value;
    logic                       phase_done;
    qspi_ctl_t                  ctl;
    logic                       cs;
    logic                       sclk;
    logic [3:0]                 io_out;
    logic [3:0]                 io_oe;

    axi_flash_slave #(
        .FLASH_ADDR_BITS(FLASH_ADDR_BITS)
    ) slave_i (
        .bus          (bus),
        .rst          (rst),
        .req          (req),
        .rsp          (rsp),
        .start_read   (start_read),
        .read_addr    (read_addr),
        .keep_reading (keep_reading),
        .byte_valid   (byte_valid),
        .data_byte    (data_byte)
    );

    qspi_sequencer #(
        .FLASH_ADDR_BITS(FLASH_ADDR_BITS),
        .DUMMY_CYCLES   (DUMMY_CYCLES)
    ) sequencer_i (
        .bus          (bus),
        .rst          (rst),
        .start_read   (start_read),
        .read_addr    (read_addr),
        .keep_reading (keep_reading),
        .phase_done   (phase_done),
        .cnt_load     (cnt_load),
        .cnt_value    (cnt_value),
        .ctl          (ctl),
        .cs           (cs),
        .sclk         (sclk)
    );

    // One counter times every phase, ticking on rising SCLK
    qspi_cycle_counter counter_i (
        .bus        (bus),
        .rst        (rst),
        .load       (cnt_load),
        .value      (cnt_value),
        .tick       (ctl.sample),
        .phase_done (phase_done)
    );

    qspi_shifter shifter_i (
        .bus        (bus),
        .rst        (rst),
        .ctl        (ctl),
        .io_in      (io_in),
        .io_out     (io_out),
        .io_oe      (io_oe),
        .byte_valid (byte_valid),
        .data_byte  (data_byte)
    );

    always_comb begin
        pins.cs     = cs;
        pins.sclk   = sclk;
        pins.io_out = io_out;
        pins.io_oe  = io_oe;
    end

endmodule

`default_nettype wire

// File: qspi_cycle_counter.sv
`timescale 1ns/1ps
`default_nettype none

module qspi_cycle_counter (
    input  logic       bus,
    input  logic       rst,
    input  logic       load,
    input  logic [7:0] value,
    input  logic       tick,
    output logic       phase_done
);

    logic [7:0] count;

    // Last SCLK period of the phase
    assign phase_done = tick && (count == 8'd1);

    // A load on the final tick starts the next phase without a gap
    always_ff @(posedge bus) begin
        if (rst) begin
            count <= 8'd0;
        end else if (load) begin
            count <= value;
        end else if (tick) begin
            count <= count - 8'd1;
        end
    end

    // Sequencer must stop sampling once a phase has run out
    no_underflow_a: assert property (@(posedge bus) disable iff (rst)
        tick |-> count != 8'd0);

endmodule

`default_nettype wire

// File: qspi_flash_model.sv
`timescale 1ns/1ps
`default_nettype none

module qspi_flash_model
    import qspi_pkg::*;
#(
    parameter int FLASH_ADDR_BITS = 24,
    parameter int DUMMY_CYCLES    = 8
) (
    input  qspi_pins_t pins,
    output logic [3:0] data_out,
    output logic       opcode_error
);

    logic                       cs;
    logic                       sclk;
    logic [7:0]                 opcode;
    logic [FLASH_ADDR_BITS-1:0] addr;
    logic [7:0]                 cur_byte;

    assign cs   = pins.cs;
    assign sclk = pins.sclk;

    // Array contents follow a fixed formula of the byte address
    function automatic logic [7:0] byte_at(input logic [FLASH_ADDR_BITS-1:0] a);
        logic [15:0] low_bits;
        low_bits = 16'(a);
        return low_bits[7:0] ^ low_bits[15:8] ^ 8'h5A;
    endfunction

    initial begin
        data_out     = 4'h0;
        opcode_error = 1'b0;
        opcode       = 8'h00;
        addr         = '0;
        cur_byte     = 8'h00;
        forever begin
            @(negedge cs);
            // Command and address arrive MSB first on lane 0
            repeat (8) begin
                @(posedge sclk);
                opcode = {opcode[6:0], pins.io_out[0]};
            end
            if (opcode != READ_QUAD_OUT) begin
                $display("Flash model: unexpected opcode %02h, only 6B is supported", opcode);
                opcode_error = 1'b1;
            end
            repeat (FLASH_ADDR_BITS) begin
                @(posedge sclk);
                addr = {addr[FLASH_ADDR_BITS-2:0], pins.io_out[0]};
            end
            repeat (DUMMY_CYCLES) @(posedge sclk);
            // High nibble first, next nibble after every falling edge
            repeat (8) begin
                cur_byte = byte_at(addr);
                @(negedge sclk);
                data_out <= cur_byte[7:4];
                @(negedge sclk);
                data_out <= cur_byte[3:0];
                addr = addr + 1'b1;
            end
            wait (cs === 1'b1);
        end
    end

endmodule

`default_nettype wire

// File: qspi_pkg.sv
`default_nettype none

package qspi_pkg;

    // Flash opcodes
    typedef enum logic [7:0] {
        READ_QUAD_OUT = 8'h6B
    } qspi_cmd_e;

    // Sequencer phases
    typedef enum logic [2:0] {
        IDLE,
        CMD,
        ADDR,
        DUMMY,
        DATA
    } seq_state_e;

    // What the shifter does with the IO lanes
    typedef enum logic [1:0] {
        NONE,
        SINGLE_OUT,
        QUAD_IN
    } lane_mode_e;

    // Flash pins, cs is active low
    typedef struct packed {
        logic       cs;
        logic       sclk;
        logic [3:0] io_out;
        logic [3:0] io_oe;
    } qspi_pins_t;

    // Sequencer order to the shifter
    typedef struct packed {
        logic        load;
        logic [31:0] load_word;   // left-aligned command or address
        lane_mode_e  mode;
        logic        shift;       // falling SCLK edge
        logic        sample;      // rising SCLK edge
    } qspi_ctl_t;

endpackage

`default_nettype wire

// File: qspi_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module qspi_sequencer
    import qspi_pkg::*;
#(
    parameter int FLASH_ADDR_BITS = 24,
    parameter int DUMMY_CYCLES    = 8
) (
    input  logic                       bus,
    input  logic                       rst,
    input  logic                       start_read,
    input  logic [FLASH_ADDR_BITS-1:0] read_addr,
    input  logic                       keep_reading,
    input  logic                       phase_done,
    output logic                       cnt_load,
    output logic [7:0]                 cnt_value,
    output qspi_ctl_t                  ctl,
    output logic                       cs,
    output logic                       sclk
);

    localparam int CMD_BITS     = 8;
    localparam int DATA_NIBBLES = 16;

    seq_state_e                 state;
    logic [FLASH_ADDR_BITS-1:0] addr_q;
    logic                       phase_edge;
    logic                       running;
    logic                       load_addr;
    logic [31:0]                addr_word;

    // Address left-aligned for the MSB-first shifter
    assign addr_word = 32'(addr_q) << (32 - FLASH_ADDR_BITS);

    // SCLK stops once the last byte has been taken by the slave
    assign running   = (state != IDLE) && !(state == DATA && !keep_reading);

    // First falling edge of ADDR replaces the spent command word
    assign load_addr = (state == ADDR) && phase_edge;

    always_comb begin
        ctl.sample    = running && !sclk;
        ctl.shift     = running && sclk && !load_addr;
        ctl.load      = (state == IDLE && start_read) || load_addr;
        ctl.load_word = (state == IDLE) ? {READ_QUAD_OUT, 24'h0} : addr_word;
        case (state)
            DUMMY:   ctl.mode = NONE;
            DATA:    ctl.mode = QUAD_IN;
            default: ctl.mode = SINGLE_OUT;
        endcase
    end

    // Counter is loaded with the length of the phase about to begin
    always_comb begin
        cnt_load = (state == IDLE && start_read) || (phase_done && state != DATA);
        case (state)
            IDLE:    cnt_value = 8'(CMD_BITS);
            CMD:     cnt_value = 8'(FLASH_ADDR_BITS);
            ADDR:    cnt_value = 8'(DUMMY_CYCLES);
            DUMMY:   cnt_value = 8'(DATA_NIBBLES);
            default: cnt_value = 8'd0;
        endcase
    end

    always_ff @(posedge bus) begin
        if (state == IDLE && start_read) begin
            addr_q <= read_addr;
        end
    end

    always_ff @(posedge bus) begin
        if (rst) begin
            state      <= IDLE;
            cs         <= 1'b1;
            sclk       <= 1'b0;
            phase_edge <= 1'b0;
        end else begin
            phase_edge <= phase_done;
            sclk       <= running ? !sclk : 1'b0;
            case (state)
                IDLE: begin
                    if (start_read) begin
                        state <= CMD;
                        cs    <= 1'b0;
                    end
                end
                CMD: begin
                    if (phase_done) begin
                        state <= ADDR;
                    end
                end
                ADDR: begin
                    if (phase_done) begin
                        state <= DUMMY;
                    end
                end
                DUMMY: begin
                    if (phase_done) begin
                        state <= DATA;
                    end
                end
                DATA: begin
                    if (!keep_reading) begin
                        state <= IDLE;
                        cs    <= 1'b1;
                    end
                end
                default: begin
                    state <= IDLE;
                    cs    <= 1'b1;
                end
            endcase
        end
    end

    // Flash deselected between accesses
    cs_idle_a: assert property (@(posedge bus) disable iff (rst)
        state == IDLE |-> cs && !sclk);

endmodule

`default_nettype wire

// File: qspi_shifter.sv
`timescale 1ns/1ps
`default_nettype none

module qspi_shifter
    import qspi_pkg::*;
(
    input  logic       bus,
    input  logic       rst,
    input  qspi_ctl_t  ctl,
    input  logic [3:0] io_in,
    output logic [3:0] io_out,
    output logic [3:0] io_oe,
    output logic       byte_valid,
    output logic [7:0] data_byte
);

    logic [31:0] sreg;
    lane_mode_e  mode_q;
    logic [3:0]  hi_nib;
    logic        have_hi;
    logic        take_nib;

    assign take_nib = ctl.sample && (ctl.mode == QUAD_IN);

    // Lane 0 carries serial data, wp and hold sit high on lanes 2 and 3
    always_comb begin
        if (mode_q == SINGLE_OUT) begin
            io_out = {2'b11, 1'b0, sreg[31]};
            io_oe  = 4'b1101;
        end else begin
            io_out = 4'b0000;
            io_oe  = 4'b0000;
        end
    end

    // Outgoing bits change on the falling SCLK edge
    always_ff @(posedge bus) begin
        if (ctl.load) begin
            sreg <= ctl.load_word;
        end else if (ctl.shift) begin
            sreg <= {sreg[30:0], 1'b0};
        end
    end

    always_ff @(posedge bus) begin
        if (take_nib) begin
            if (have_hi) begin
                data_byte <= {hi_nib, io_in};
            end else begin
                hi_nib <= io_in;
            end
        end
    end

    always_ff @(posedge bus) begin
        if (rst) begin
            mode_q     <= NONE;
            have_hi    <= 1'b0;
            byte_valid <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            if (ctl.load || ctl.shift) begin
                mode_q <= ctl.mode;
            end
            if (ctl.load) begin
                have_hi <= 1'b0;
            end else if (take_nib) begin
                // high nibble first
                have_hi    <= !have_hi;
                byte_valid <= have_hi;
            end
        end
    end

endmodule

`default_nettype wire

// File: tb_flash_xip.sv
`timescale 1ns/1ps
`default_nettype none

module tb_flash_xip
    import axi_lite_pkg::*;
    import qspi_pkg::*;
();

    localparam int          FLASH_ADDR_BITS = 24;
    localparam int          DUMMY_CYCLES    = 8;
    localparam int          RESET_CYCLES    = 10;
    localparam int          READ_COUNT      = 26;
    localparam int          WRITE_COUNT     = 2;
    localparam int          TEST_COUNT      = READ_COUNT + WRITE_COUNT;
    localparam logic [31:0] ADDR_MASK       = (32'd1 << FLASH_ADDR_BITS) - 1;

    logic        bus;
    logic        rst;
    axi_req_t    req;
    axi_rsp_t    rsp;
    qspi_pins_t  pins;
    logic [3:0]  io_in;
    logic        opcode_error;
    logic [63:0] exp_q[$];
    int          seed = 32'he340;
    int          reads_done = 0;
    int          writes_done = 0;
    logic        rvalid_seen = 1'b0;
    logic [31:0] addr;
    int          delay;
    int          i;

    flash_xip_top #(
        .FLASH_ADDR_BITS(FLASH_ADDR_BITS),
        .DUMMY_CYCLES   (DUMMY_CYCLES)
    ) dut_i (
        .bus   (bus),
        .rst   (rst),
        .req   (req),
        .rsp   (rsp),
        .pins  (pins),
        .io_in (io_in)
    );

    qspi_flash_model #(
        .FLASH_ADDR_BITS(FLASH_ADDR_BITS),
        .DUMMY_CYCLES   (DUMMY_CYCLES)
    ) flash_i (
        .pins         (pins),
        .data_out     (io_in),
        .opcode_error (opcode_error)
    );

    initial begin
        bus = 1'b0;
        forever #10 bus = ~bus;
    end

    // Expected beat, byte n comes from address addr+n
    function automatic logic [63:0] flash_word(input logic [31:0] start);
        logic [63:0] word;
        logic [31:0] a;
        int          n;
        word = '0;
        for (n = 0; n < 8; n++) begin
            a = (start + n) & ADDR_MASK;
            word[8*n +: 8] = a[7:0] ^ a[15:8] ^ 8'h5A;
        end
        return word;
    endfunction

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] expected);
        if (got !== expected) begin
            $display("FAIL time=%0t signal=%s got=%0h expected=%0h", $time, name, got, expected);
            $display("ERRORS FOUND");
            $fatal(1, "Value mismatch");
        end
    endtask

    task automatic read_word(input logic [31:0] read_addr, input int rdelay);
        @(posedge bus);
        req.arvalid <= 1'b1;
        req.araddr  <= read_addr;
        do @(posedge bus); while (!rsp.arready);
        req.arvalid <= 1'b0;
        do @(posedge bus); while (!rsp.rvalid);
        repeat (rdelay) @(posedge bus);
        req.rready <= 1'b1;
        @(posedge bus);
        req.rready <= 1'b0;
    endtask

    task automatic write_word(input int bdelay);
        @(posedge bus);
        req.awvalid <= 1'b1;
        req.awaddr  <= $random(seed) & ADDR_MASK;
        req.wvalid  <= 1'b1;
        req.wdata   <= {$random(seed), $random(seed)};
        req.wstrb   <= 8'hFF;
        do @(posedge bus); while (!rsp.awready);
        check("rsp.wready", rsp.wready, 1'b1);
        req.awvalid <= 1'b0;
        req.wvalid  <= 1'b0;
        do @(posedge bus); while (!rsp.bvalid);
        repeat (bdelay) @(posedge bus);
        req.bready <= 1'b1;
        @(posedge bus);
        req.bready <= 1'b0;
    endtask

    // Every cycle with rvalid high is compared, so held data is covered too
    always @(posedge bus) begin
        if (!rst) begin
            if (rsp.arready && req.arvalid) begin
                exp_q.push_back(flash_word(req.araddr & ADDR_MASK));
            end
            if (rsp.rvalid) begin
                check("expected queue depth", exp_q.size(), 1);
                check("rsp.rdata", rsp.rdata, exp_q[0]);
                check("rsp.arready", rsp.arready, 1'b0);
                check("pins.io_oe", pins.io_oe, 4'h0);
                // Flash is deselected one cycle after the last byte lands
                if (rvalid_seen) begin
                    check("pins.cs", pins.cs, 1'b1);
                end
                if (req.rready) begin
                    check("rsp.rresp", rsp.rresp, OKAY);
                    exp_q.pop_front();
                    reads_done++;
                end
            end
            rvalid_seen <= rsp.rvalid;
            if (rsp.bvalid && req.bready) begin
                check("rsp.bresp", rsp.bresp, SLVERR);
                writes_done++;
            end
        end
    end

    always @(posedge bus) begin
        if (opcode_error) begin
            $display("The flash model received a command other than Quad Output Fast Read");
            $display("ERRORS FOUND");
            $fatal(1, "Wrong flash opcode");
        end
    end

    // Worst read is about 130 cycles, 200 per test leaves margin
    initial begin
        repeat (TEST_COUNT * 200 + RESET_CYCLES + 20) @(posedge bus);
        $display("Timeout: the DUT stopped answering before all tests had finished");
        $display("ERRORS FOUND");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        rst = 1'b1;
        req = '0;
        repeat (RESET_CYCLES) @(posedge bus);
        rst <= 1'b0;
        @(posedge bus);
        check("rsp.arready", rsp.arready, 1'b1);
        check("rsp.rvalid", rsp.rvalid, 1'b0);
        check("rsp.bvalid", rsp.bvalid, 1'b0);
        check("pins.cs", pins.cs, 1'b1);
        check("pins.sclk", pins.sclk, 1'b0);

        read_word(32'h0, 0);
        for (i = 0; i < 20; i++) begin
            addr = $random(seed) & ADDR_MASK;
            read_word(addr, 0);
        end

        // R back-pressure
        for (i = 0; i < 4; i++) begin
            addr  = $random(seed) & ADDR_MASK;
            delay = 1 + ($unsigned($random(seed)) % 24);
            read_word(addr, delay);
        end

        write_word(0);
        delay = 1 + ($unsigned($random(seed)) % 16);
        write_word(delay);
        addr = $random(seed) & ADDR_MASK;
        read_word(addr, 0);

        repeat (4) @(posedge bus);
        check("pins.cs", pins.cs, 1'b1);
        check("reads completed", reads_done, READ_COUNT);
        check("writes completed", writes_done, WRITE_COUNT);
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire
